/* hdl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W = 24;     // Halfword address
    localparam int DATA_W = 16;
    localparam int OFF_W = 2;       // Four halfwords per line
    localparam int LINE_W = 64;
    localparam int IDX_W_DEFAULT = 6;
    localparam int TAG_W_DEFAULT = ADDR_W - IDX_W_DEFAULT - OFF_W;

    // Everything below this address belongs to the protected zero page
    localparam logic [ADDR_W-1:0] FIRST_PAGE_DEFAULT = 24'h000800;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [1:0]        sel;        // Bit 0 is the low byte
        logic              we;
        logic              cacheable;
    } cpu_req_t;

    // A narrower tag from a wider index sits zero-extended in the low bits
    typedef struct packed {
        logic [TAG_W_DEFAULT-1:0] tag;
        logic [LINE_W-1:0]        line;
        logic                     dirty;
        logic                     valid;
    } cache_entry_t;

    typedef enum logic [1:0] {
        OP_SINGLE_RD,
        OP_SINGLE_WR,
        OP_LINE_FILL,
        OP_LINE_WB
    } line_op_t;

    typedef struct packed {
        line_op_t          op;
        logic [ADDR_W-1:0] adr;    // Line base for bursts, beat address for singles
        logic [DATA_W-1:0] wdata;
        logic [1:0]        sel;
        logic [LINE_W-1:0] line;   // Victim line for a writeback
    } line_cmd_t;

endpackage

`default_nettype wire

/* hdl/dcache_way_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_way_ram #(
    parameter int P_IDX_W = 6
) (
    input  wire logic                      i_clk,
    input  wire logic [P_IDX_W-1:0]        i_idx,
    input  wire logic                      i_we,
    input  wire dcache_pkg::cache_entry_t  i_wentry,
    output dcache_pkg::cache_entry_t       o_rentry
);
    import dcache_pkg::*;

    localparam int DEPTH = 2 ** P_IDX_W;

    cache_entry_t mem [DEPTH];

    // Read returns the old entry when the same set is written in that cycle
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_idx] <= i_wentry;
        end
        o_rentry <= mem[i_idx];
    end

endmodule

`default_nettype wire

/* hdl/dcache_req_port.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_req_port #(
    parameter logic [dcache_pkg::ADDR_W-1:0] P_FIRST_PAGE = dcache_pkg::FIRST_PAGE_DEFAULT
) (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    input  wire logic                           i_ready,
    input  wire logic                           i_req,
    input  wire logic                           i_we,
    input  wire logic [dcache_pkg::ADDR_W-1:0]  i_addr,
    input  wire logic [dcache_pkg::DATA_W-1:0]  i_wdata,
    input  wire logic [1:0]                     i_sel,
    input  wire logic                           i_cacheable,
    input  wire logic                           i_req_done,
    output logic                                o_req_valid,
    output dcache_pkg::cpu_req_t                o_req,
    output logic                                o_exception
);
    import dcache_pkg::*;

    logic taken;       // Current i_req already accepted
    logic accept;
    logic illegal;

    assign illegal = i_addr < P_FIRST_PAGE;
    assign accept = i_ready && i_req && !taken && !o_req_valid;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_req_valid <= 1'b0;
            o_exception <= 1'b0;
            taken       <= 1'b0;
        end else begin
            o_exception <= 1'b0;
            if (!i_req) begin
                taken <= 1'b0;
            end
            if (o_req_valid && i_req_done) begin
                o_req_valid <= 1'b0;
            end else if (accept) begin
                taken <= 1'b1;
                if (illegal) begin
                    o_exception <= 1'b1;   // Refused, never reaches the controller
                end else begin
                    o_req_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_req <= '{addr: i_addr, wdata: i_wdata, sel: i_sel, we: i_we,
                       cacheable: i_cacheable};
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int P_IDX_W = dcache_pkg::IDX_W_DEFAULT
) (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    input  wire logic                           i_req_valid,
    input  wire dcache_pkg::cpu_req_t           i_req,
    output logic                                o_req_done,
    output logic                                o_ack,
    output logic [dcache_pkg::DATA_W-1:0]       o_rdata,
    output logic [P_IDX_W-1:0]                  o_idx,
    output logic [1:0]                          o_way_we,
    output dcache_pkg::cache_entry_t            o_wentry,
    input  wire dcache_pkg::cache_entry_t       i_rentry0,
    input  wire dcache_pkg::cache_entry_t       i_rentry1,
    output logic                                o_cmd_valid,
    output dcache_pkg::line_cmd_t               o_cmd,
    input  wire logic                           i_cmd_done,
    input  wire logic [dcache_pkg::LINE_W-1:0]  i_fill_line,
    input  wire logic [dcache_pkg::DATA_W-1:0]  i_rdata_single,
    output logic                                o_ready
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - P_IDX_W - OFF_W;

    typedef enum logic [2:0] {
        S_SWEEP, S_IDLE, S_LOOKUP, S_COMPARE, S_MERGE, S_WB, S_FILL, S_SINGLE
    } state_t;

    state_t                   state;
    logic [P_IDX_W-1:0]       sweep_idx;
    logic [P_IDX_W-1:0]       req_idx;
    logic [OFF_W-1:0]         req_off;
    logic [TAG_W_DEFAULT-1:0] req_tag;
    logic [1:0]               hit;
    logic                     victim;
    logic                     hit_q;
    logic                     way_q;        // Hit way, or the victim on a miss
    logic                     last_victim;
    cache_entry_t             sel_entry;
    logic [LINE_W-1:0]        merge_src;
    logic [LINE_W-1:0]        merged_line;

    function automatic logic [LINE_W-1:0] merge_line(input logic [LINE_W-1:0] line,
                                                     input logic [OFF_W-1:0]  off,
                                                     input logic [DATA_W-1:0] wdata,
                                                     input logic [1:0]        sel);
        logic [LINE_W-1:0] res;
        res = line;
        if (sel[0]) res[off*DATA_W +: 8] = wdata[7:0];
        if (sel[1]) res[off*DATA_W + 8 +: 8] = wdata[15:8];
        return res;
    endfunction

    assign req_idx = i_req.addr[OFF_W +: P_IDX_W];
    assign req_off = i_req.addr[OFF_W-1:0];
    assign req_tag = TAG_W_DEFAULT'(i_req.addr[ADDR_W-1 -: TAG_W]);

    assign hit[0] = i_rentry0.valid && (i_rentry0.tag == req_tag);
    assign hit[1] = i_rentry1.valid && (i_rentry1.tag == req_tag);

    // Invalid way first, then a clean one, else alternate
    always_comb begin
        if (!i_rentry0.valid)      victim = 1'b0;
        else if (!i_rentry1.valid) victim = 1'b1;
        else if (!i_rentry0.dirty) victim = 1'b0;
        else if (!i_rentry1.dirty) victim = 1'b1;
        else                       victim = ~last_victim;
    end

    assign sel_entry = way_q ? i_rentry1 : i_rentry0;
    assign merge_src = (state == S_FILL) ? i_fill_line : sel_entry.line;
    assign merged_line = merge_line(merge_src, req_off, i_req.wdata, i_req.sel);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= S_SWEEP;
            sweep_idx   <= '0;
            hit_q       <= 1'b0;
            way_q       <= 1'b0;
            last_victim <= 1'b0;
        end else begin
            case (state)
                S_SWEEP: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    if (&sweep_idx) state <= S_IDLE;
                end
                S_IDLE: begin
                    if (i_req_valid) state <= i_req.cacheable ? S_LOOKUP : S_SINGLE;
                end
                S_LOOKUP: begin
                    hit_q <= |hit;
                    way_q <= (|hit) ? hit[1] : victim;
                    state <= S_COMPARE;
                end
                S_COMPARE: begin
                    if (hit_q) begin
                        state <= i_req.we ? S_MERGE : S_IDLE;
                    end else begin
                        last_victim <= way_q;
                        // Only a dirty victim needs a writeback burst first
                        state <= (sel_entry.valid && sel_entry.dirty) ? S_WB : S_FILL;
                    end
                end
                S_WB: if (i_cmd_done) state <= S_FILL;
                S_FILL, S_SINGLE: if (i_cmd_done) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    assign o_ready = (state != S_SWEEP);
    assign o_idx = (state == S_SWEEP) ? sweep_idx : req_idx;

    always_comb begin
        o_way_we = '0;
        case (state)
            S_SWEEP: o_way_we = 2'b11;
            S_MERGE: o_way_we[way_q] = 1'b1;
            S_FILL:  o_way_we[way_q] = i_cmd_done;
            default: o_way_we = '0;
        endcase
    end

    // A write miss merges straight into the fetched line
    always_comb begin
        if (state == S_SWEEP) begin
            o_wentry = '0;
        end else begin
            o_wentry.tag   = req_tag;
            o_wentry.line  = i_req.we ? merged_line : merge_src;
            o_wentry.dirty = i_req.we;
            o_wentry.valid = 1'b1;
        end
    end

    assign o_ack = (state == S_COMPARE && hit_q && !i_req.we) || (state == S_MERGE)
                || ((state == S_FILL || state == S_SINGLE) && i_cmd_done);
    assign o_req_done = o_ack;
    assign o_rdata = (state == S_SINGLE) ? i_rdata_single : merge_src[req_off*DATA_W +: DATA_W];

    assign o_cmd_valid = (state == S_WB) || (state == S_FILL) || (state == S_SINGLE);

    always_comb begin
        o_cmd.wdata = i_req.wdata;
        o_cmd.sel   = i_req.sel;
        o_cmd.line  = sel_entry.line;
        case (state)
            S_WB: begin
                o_cmd.op  = OP_LINE_WB;
                o_cmd.adr = {sel_entry.tag[TAG_W-1:0], req_idx, {OFF_W{1'b0}}};
            end
            S_FILL: begin
                o_cmd.op  = OP_LINE_FILL;
                o_cmd.adr = {i_req.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
            end
            default: begin
                o_cmd.op  = i_req.we ? OP_SINGLE_WR : OP_SINGLE_RD;
                o_cmd.adr = i_req.addr;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/wb_line_master.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_line_master (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    input  wire logic                           i_cmd_valid,
    input  wire dcache_pkg::line_cmd_t          i_cmd,
    output logic                                o_cmd_done,
    output logic [dcache_pkg::LINE_W-1:0]       o_fill_line,
    output logic [dcache_pkg::DATA_W-1:0]       o_rdata_single,
    output logic                                o_wb_cyc,
    output logic                                o_wb_stb,
    output logic                                o_wb_we,
    output logic [dcache_pkg::ADDR_W-1:0]       o_wb_adr,
    output logic [dcache_pkg::DATA_W-1:0]       o_wb_dat,
    output logic [1:0]                          o_wb_sel,
    output logic                                o_wb_burst,
    input  wire logic [dcache_pkg::DATA_W-1:0]  i_wb_dat,
    input  wire logic                           i_wb_ack
);
    import dcache_pkg::*;

    line_cmd_t         cmd_q;
    logic [OFF_W-1:0]  beat;
    logic              is_line;
    logic              beat_ok;
    logic              last_beat;
    logic              start;

    assign is_line = (cmd_q.op == OP_LINE_FILL) || (cmd_q.op == OP_LINE_WB);
    assign beat_ok = o_wb_cyc && o_wb_stb && i_wb_ack;
    assign last_beat = !is_line || (&beat);
    // The done cycle still sees the old command valid, so it must not restart
    assign start = !o_wb_cyc && i_cmd_valid && !o_cmd_done;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_cyc   <= 1'b0;
            o_wb_stb   <= 1'b0;
            o_cmd_done <= 1'b0;
            beat       <= '0;
        end else begin
            o_cmd_done <= 1'b0;
            if (start) begin
                o_wb_cyc <= 1'b1;
                o_wb_stb <= 1'b1;
                beat     <= '0;
            end else if (beat_ok) begin
                beat <= beat + 1'b1;
                if (last_beat) begin
                    o_wb_cyc   <= 1'b0;
                    o_wb_stb   <= 1'b0;
                    o_cmd_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            cmd_q <= i_cmd;
        end
        if (beat_ok) begin
            o_fill_line[beat*DATA_W +: DATA_W] <= i_wb_dat;
            o_rdata_single <= i_wb_dat;
        end
    end

    assign o_wb_we = o_wb_cyc && ((cmd_q.op == OP_SINGLE_WR) || (cmd_q.op == OP_LINE_WB));
    assign o_wb_burst = o_wb_cyc && is_line;
    assign o_wb_adr = is_line ? {cmd_q.adr[ADDR_W-1:OFF_W], beat} : cmd_q.adr;
    assign o_wb_dat = is_line ? cmd_q.line[beat*DATA_W +: DATA_W] : cmd_q.wdata;
    assign o_wb_sel = is_line ? 2'b11 : cmd_q.sel;   // Whole halfwords on line bursts

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int P_IDX_W = dcache_pkg::IDX_W_DEFAULT,
    parameter logic [dcache_pkg::ADDR_W-1:0] P_FIRST_PAGE = dcache_pkg::FIRST_PAGE_DEFAULT
) (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    input  wire logic                           i_req,
    input  wire logic                           i_we,
    input  wire logic [dcache_pkg::ADDR_W-1:0]  i_addr,
    input  wire logic [dcache_pkg::DATA_W-1:0]  i_wdata,
    input  wire logic [1:0]                     i_sel,
    input  wire logic                           i_cacheable,
    output logic                                o_ack,
    output logic [dcache_pkg::DATA_W-1:0]       o_rdata,
    output logic                                o_exception,
    output logic                                o_wb_cyc,
    output logic                                o_wb_stb,
    output logic                                o_wb_we,
    output logic [dcache_pkg::ADDR_W-1:0]       o_wb_adr,
    output logic [dcache_pkg::DATA_W-1:0]       o_wb_dat,
    output logic [1:0]                          o_wb_sel,
    output logic                                o_wb_burst,
    input  wire logic [dcache_pkg::DATA_W-1:0]  i_wb_dat,
    input  wire logic                           i_wb_ack
);
    import dcache_pkg::*;

    logic                 req_valid;
    cpu_req_t             req;
    logic                 req_done;
    logic                 ready;
    logic [P_IDX_W-1:0]   idx;
    logic [1:0]           way_we;
    cache_entry_t         wentry;
    cache_entry_t         rentry0;
    cache_entry_t         rentry1;
    logic                 cmd_valid;
    line_cmd_t            cmd;
    logic                 cmd_done;
    logic [LINE_W-1:0]    fill_line;
    logic [DATA_W-1:0]    rdata_single;

    dcache_req_port #(.P_FIRST_PAGE(P_FIRST_PAGE)) u_req_port (
        .i_clk, .i_rst, .i_ready(ready), .i_req, .i_we, .i_addr, .i_wdata, .i_sel,
        .i_cacheable, .i_req_done(req_done), .o_req_valid(req_valid), .o_req(req),
        .o_exception
    );

    dcache_ctrl #(.P_IDX_W(P_IDX_W)) u_ctrl (
        .i_clk, .i_rst, .i_req_valid(req_valid), .i_req(req), .o_req_done(req_done),
        .o_ack, .o_rdata, .o_idx(idx), .o_way_we(way_we), .o_wentry(wentry),
        .i_rentry0(rentry0), .i_rentry1(rentry1), .o_cmd_valid(cmd_valid), .o_cmd(cmd),
        .i_cmd_done(cmd_done), .i_fill_line(fill_line), .i_rdata_single(rdata_single),
        .o_ready(ready)
    );

    dcache_way_ram #(.P_IDX_W(P_IDX_W)) u_way0 (
        .i_clk, .i_idx(idx), .i_we(way_we[0]), .i_wentry(wentry), .o_rentry(rentry0)
    );

    dcache_way_ram #(.P_IDX_W(P_IDX_W)) u_way1 (
        .i_clk, .i_idx(idx), .i_we(way_we[1]), .i_wentry(wentry), .o_rentry(rentry1)
    );

    wb_line_master u_wb_master (
        .i_clk, .i_rst, .i_cmd_valid(cmd_valid), .i_cmd(cmd), .o_cmd_done(cmd_done),
        .o_fill_line(fill_line), .o_rdata_single(rdata_single), .o_wb_cyc, .o_wb_stb,
        .o_wb_we, .o_wb_adr, .o_wb_dat, .o_wb_sel, .o_wb_burst, .i_wb_dat, .i_wb_ack
    );

endmodule

`default_nettype wire

/* verification/dcache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_checker #(
    parameter logic [dcache_pkg::ADDR_W-1:0] P_FIRST_PAGE = dcache_pkg::FIRST_PAGE_DEFAULT
) (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    input  wire logic                           i_req,
    input  wire logic                           i_we,
    input  wire logic [dcache_pkg::ADDR_W-1:0]  i_addr,
    input  wire logic [dcache_pkg::DATA_W-1:0]  i_wdata,
    input  wire logic [1:0]                     i_sel,
    input  wire logic                           i_cacheable,
    input  wire logic                           i_ack,
    input  wire logic [dcache_pkg::DATA_W-1:0]  i_rdata,
    input  wire logic                           i_exception,
    input  wire logic                           i_wb_cyc,
    input  wire logic                           i_wb_stb,
    input  wire logic                           i_wb_we,
    input  wire logic                           i_wb_ack,
    input  wire logic                           i_wb_burst,
    input  wire logic [dcache_pkg::ADDR_W-1:0]  i_wb_adr,
    input  wire logic [dcache_pkg::DATA_W-1:0]  i_wb_dat,
    input  wire logic [1:0]                     i_wb_sel,
    output int                                  o_errors,
    output int                                  o_checks
);
    import dcache_pkg::*;

    logic [DATA_W-1:0]       ref_mem [logic [ADDR_W-1:0]];   // Flat halfword memory
    logic                    busy;
    logic                    illegal;
    logic                    hit_expected;
    logic [ADDR_W-1:OFF_W]   last_line;    // Line of the latest cacheable access
    logic                    last_line_ok;
    logic [OFF_W-1:0]        burst_pos;
    int                      age;
    int                      beats;
    int                      err_count = 0;
    int                      chk_count = 0;

    assign o_errors = err_count;
    assign o_checks = chk_count;

    // Unwritten memory holds a pattern made from the whole address
    function automatic logic [DATA_W-1:0] fill_value(input logic [ADDR_W-1:0] addr);
        return addr[15:0] ^ {addr[23:16], addr[23:16]} ^ 16'h5a3c;
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
        if (ref_mem.exists(addr)) return ref_mem[addr];
        return fill_value(addr);
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] data,
                                                      input logic [1:0]        sel);
        return {sel[1] ? data[15:8] : old[15:8], sel[0] ? data[7:0] : old[7:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_count = chk_count + 1;
        if (got !== exp) begin
            err_count = err_count + 1;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_text(input string msg, input logic [ADDR_W-1:0] addr);
        err_count = err_count + 1;
        $display("ERROR at %0t: %s (address 0x%06h)", $time, msg, addr);
    endtask

    task automatic check_beat();
        beats = beats + 1;
        if (!i_cacheable) begin
            check_value("o_wb_burst", 32'(i_wb_burst), 32'd0);
            check_value("o_wb_we", 32'(i_wb_we), 32'(i_we));
            check_value("o_wb_adr", 32'(i_wb_adr), 32'(i_addr));
            check_value("o_wb_sel", 32'(i_wb_sel), 32'(i_sel));
            if (i_we) begin
                check_value("o_wb_dat", 32'(i_wb_dat), 32'(i_wdata));
            end
        end else begin
            check_value("o_wb_burst", 32'(i_wb_burst), 32'd1);
            check_value("o_wb_adr offset", 32'(i_wb_adr[OFF_W-1:0]), 32'(burst_pos));
            burst_pos = burst_pos + 2'd1;
        end
    endtask

    task automatic check_ack();
        if (!i_cacheable) begin
            check_value("single beat count", 32'(beats), 32'd1);
        end else if (hit_expected) begin
            check_value("hit beat count", 32'(beats), 32'd0);
            check_value("hit ack latency", 32'(age), i_we ? 32'd4 : 32'd3);
        end else if (beats % 4 != 0) begin
            report_text("cacheable access ended inside a line burst", i_addr);
        end
        if (i_we) begin
            ref_mem[i_addr] = merge_bytes(expected_read(i_addr), i_wdata, i_sel);
        end else begin
            check_value("o_rdata", 32'(i_rdata), 32'(expected_read(i_addr)));
        end
        if (i_cacheable) begin
            last_line    = i_addr[ADDR_W-1:OFF_W];
            last_line_ok = 1'b1;
        end
    endtask

    always @(posedge i_clk) begin
        if (i_rst) begin
            busy         = 1'b0;
            last_line_ok = 1'b0;
            burst_pos    = '0;
        end else begin
            if (!i_wb_cyc) burst_pos = '0;   // Every burst starts at offset 0
            // A refused address never reaches the bus
            if (i_wb_cyc && i_wb_stb && i_wb_ack && i_wb_adr < P_FIRST_PAGE) begin
                report_text("bus beat below the first legal page", i_wb_adr);
            end
            if (busy) begin
                age = age + 1;
                if (i_wb_cyc && i_wb_stb && i_wb_ack) check_beat();
                if (illegal) begin
                    if (age == 1) begin
                        busy = 1'b0;
                        check_value("o_exception", 32'(i_exception), 32'd1);
                    end
                end else if (i_exception) begin
                    busy = 1'b0;
                    report_text("exception for a legal address", i_addr);
                end else if (i_ack) begin
                    busy = 1'b0;
                    check_ack();
                end
            end else if (i_req) begin
                busy         = 1'b1;
                age          = 0;
                beats        = 0;
                illegal      = i_addr < P_FIRST_PAGE;
                hit_expected = i_cacheable && last_line_ok
                            && (last_line == i_addr[ADDR_W-1:OFF_W]);
            end else if (i_ack || i_exception) begin
                report_text("response with no request in flight", i_addr);
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int IDX_W = IDX_W_DEFAULT;
    localparam int NUM_REQ = 400;
    localparam int SWEEP_CYCLES = 2 ** IDX_W;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 60 + SWEEP_CYCLES + 10;
    localparam logic [31:0] SEED = 32'h7fd6b209;

    logic               clk = 1'b0;
    logic               rst;
    logic               req;
    logic               we;
    logic [ADDR_W-1:0]  addr;
    logic [DATA_W-1:0]  wdata;
    logic [1:0]         sel;
    logic               cacheable;
    logic               ack;
    logic [DATA_W-1:0]  rdata;
    logic               exception;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [ADDR_W-1:0]  wb_adr;
    logic [DATA_W-1:0]  wb_dat_out;
    logic [1:0]         wb_sel;
    logic               wb_burst;
    logic [DATA_W-1:0]  wb_dat;
    logic               wb_ack;
    logic [31:0]        stim_lfsr;
    logic [31:0]        bus_lfsr;
    logic [ADDR_W-1:0]  last_cached;
    logic [1:0]         wait_left;
    logic [DATA_W-1:0]  bus_mem [logic [ADDR_W-1:0]];
    int                 errors;
    int                 checks;

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[14:0], state[0]};
            state = lfsr_step(state);
        end
    endtask

    function automatic logic [15:0] tag_of(input logic [1:0] k);
        case (k)
            2'd0:    return 16'h0008;
            2'd1:    return 16'h0123;
            2'd2:    return 16'h0a55;
            default: return 16'h7f00;
        endcase
    endfunction

    // Same rule as the checker for memory that was never written
    function automatic logic [DATA_W-1:0] bus_word(input logic [ADDR_W-1:0] a);
        if (bus_mem.exists(a)) return bus_mem[a];
        return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5a3c;
    endfunction

    task automatic run_request();
        logic [15:0] kind;
        logic [15:0] bits;
        cpu_req_t    r;
        draw_bits(stim_lfsr, 4, kind);
        draw_bits(stim_lfsr, 1, bits);
        r.we = bits[0];
        draw_bits(stim_lfsr, 2, bits);
        r.sel = (bits[1:0] == 2'b00) ? 2'b11 : bits[1:0];
        draw_bits(stim_lfsr, 16, bits);
        r.wdata = bits;
        draw_bits(stim_lfsr, 11, bits);
        r.cacheable = 1'b1;
        if (kind == 16'd0) begin
            r.addr = {13'd0, bits[10:0]};             // Below the first legal page
        end else if (kind <= 16'd2) begin
            r.addr = {16'h0300, 5'd0, bits[2:0]};     // Uncached window that is never cached
            r.cacheable = 1'b0;
        end else if (kind <= 16'd6) begin
            r.addr = {last_cached[ADDR_W-1:OFF_W], bits[1:0]};
        end else begin
            // Four tags over two sets keep both ways busy
            r.addr = {tag_of(bits[1:0]), bits[2] ? 6'd37 : 6'd5, bits[4:3]};
            last_cached = r.addr;
        end
        @(posedge clk);
        req       <= 1'b1;
        we        <= r.we;
        addr      <= r.addr;
        wdata     <= r.wdata;
        sel       <= r.sel;
        cacheable <= r.cacheable;
        do @(posedge clk); while (!(ack || exception));
        req <= 1'b0;
    endtask

    // Wishbone memory with 0 to 3 wait cycles per beat
    always @(posedge clk) begin : wb_memory
        logic [15:0]       waits;
        logic [DATA_W-1:0] old_word;
        if (rst) begin
            wb_ack    <= 1'b0;
            wait_left <= '0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (wait_left != 2'd0) begin
                    wait_left <= wait_left - 2'd1;
                end else begin
                    wb_ack <= 1'b1;
                    if (wb_we) begin
                        old_word = bus_word(wb_adr);
                        bus_mem[wb_adr] = {wb_sel[1] ? wb_dat_out[15:8] : old_word[15:8],
                                           wb_sel[0] ? wb_dat_out[7:0] : old_word[7:0]};
                    end else begin
                        wb_dat <= bus_word(wb_adr);
                    end
                    draw_bits(bus_lfsr, 2, waits);
                    wait_left <= waits[1:0];
                end
            end
        end
    end

    dcache_top #(.P_IDX_W(IDX_W), .P_FIRST_PAGE(FIRST_PAGE_DEFAULT)) u_dut (
        .i_clk(clk), .i_rst(rst), .i_req(req), .i_we(we), .i_addr(addr), .i_wdata(wdata),
        .i_sel(sel), .i_cacheable(cacheable), .o_ack(ack), .o_rdata(rdata),
        .o_exception(exception), .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we),
        .o_wb_adr(wb_adr), .o_wb_dat(wb_dat_out), .o_wb_sel(wb_sel), .o_wb_burst(wb_burst),
        .i_wb_dat(wb_dat), .i_wb_ack(wb_ack)
    );

    dcache_checker #(.P_FIRST_PAGE(FIRST_PAGE_DEFAULT)) u_checker (
        .i_clk(clk), .i_rst(rst), .i_req(req), .i_we(we), .i_addr(addr), .i_wdata(wdata),
        .i_sel(sel), .i_cacheable(cacheable), .i_ack(ack), .i_rdata(rdata),
        .i_exception(exception), .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
        .i_wb_ack(wb_ack), .i_wb_burst(wb_burst), .i_wb_adr(wb_adr), .i_wb_dat(wb_dat_out),
        .i_wb_sel(wb_sel), .o_errors(errors), .o_checks(checks)
    );

    initial begin
        rst         = 1'b1;
        req         = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        sel         = 2'b11;
        cacheable   = 1'b1;
        wb_dat      = '0;
        wb_ack      = 1'b0;
        stim_lfsr   = SEED;
        bus_lfsr    = SEED;
        last_cached = {tag_of(2'd0), 6'd5, 2'd0};
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (SWEEP_CYCLES) @(posedge clk);   // Way RAMs are cleared set by set
        for (int n = 0; n < NUM_REQ; n++) begin
            run_request();
        end
        repeat (3) @(posedge clk);
        $display("Requests %0d, checks %0d, errors %0d", NUM_REQ, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the requests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/dcache_pkg.sv
hdl/dcache_way_ram.sv
hdl/dcache_req_port.sv
hdl/dcache_ctrl.sv
hdl/wb_line_master.sv
hdl/dcache_top.sv
verification/dcache_checker.sv
verification/tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcache
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell cat $(FLIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The run fails unless the simulation prints the pass message
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
